// ==== sim.f ====
+incdir+common
common/tex_pkg.sv
common/tex_cache_if.sv
common/tex_param_if.sv
hdl/tex_param_regs.sv
bilinear/tex_bilinear_unit.sv
cache/tex_cache_core.sv
hdl/tex_sampler_top.sv
dv/tex_sampler_assert.sv
dv/tex_sampler_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the texture sampler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tex_sampler_tb -f sim.f \
	&& ./obj_dir/Vtex_sampler_tb | tee /dev/stderr | grep -qx "test passed" \
	&& echo "simulation ok" \
	|| { echo "simulation FAILED"; exit 1; }

// ==== dv/tex_sampler_tb.sv ====
// ------------------------------------------------
// texture sampler testbench
// random samples against a bilinear model
// with a memory model and random back-pressure
// ------------------------------------------------

`timescale 1ns/1ps

`include "tex_cfg.svh"

module tex_sampler_tb import tex_pkg::*; ();

	localparam int CLK_PERIOD  = 100;
	localparam int NUM_RANDOM  = 40;
	localparam int NUM_BORDER  = 8;
	localparam int NUM_SAMPLES = NUM_RANDOM + NUM_BORDER + 4 + 3;
	localparam int NUM_WRITES  = 5;
	localparam int TIMEOUT_NS  = (NUM_SAMPLES + NUM_WRITES) * 200 * CLK_PERIOD;

	logic       clk         = 1'b0;
	logic       rst         = 1'b1;
	logic       param_wr    = 1'b0;
	logic [1:0] param_sel   = 2'd0;
	tex_addr_t  param_wdata = '0;
	logic       clear_busy;
	tex_coord_t s_x         = '0;
	tex_coord_t s_y         = '0;
	tex_user_t  s_user      = '0;
	logic       s_valid     = 1'b0;
	logic       s_ready;
	texel_t     m_data;
	tex_user_t  m_user;
	logic       m_valid;
	logic       m_ready     = 1'b0;
	logic       mem_arvalid;
	tex_addr_t  mem_araddr;
	logic       mem_arready = 1'b0;
	logic       mem_rvalid  = 1'b0;
	texel_t     mem_rdata   = '0;

	logic [31:0] lfsr = 32'he1c8596a;

	// memory model state
	logic      acc_seen = 1'b0;
	tex_addr_t acc_addr = '0;
	logic      rd_pend  = 1'b0;
	int        rd_wait  = 0;
	int        mem_reads = 0;

	// in-image texel addresses still expected for this sample
	tex_addr_t exp_addrs [$];

	// last output taken by the monitor
	texel_t    got_data;
	tex_user_t got_user;
	int        outputs_seen = 0;

	// shadow of the parameter registers
	tex_addr_t cfg_base   = '0;
	int        cfg_width  = 0;
	int        cfg_height = 0;
	tex_addr_t cfg_stride = '0;

	string cur_test = "";
	int    checks = 0;
	int    errors = 0;
	int    tests_run = 0;
	int    tests_failing = 0;
	int    test_err_start = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	tex_sampler_top tex_sampler_top_inst (.*);

	// ------------------------------------------------
	// monitors on the rising edge
	// ------------------------------------------------

	always @(posedge clk) begin
		acc_seen <= !rst && mem_arvalid && mem_arready;
		acc_addr <= mem_araddr;
		if (!rst && m_valid && m_ready) begin
			got_data     <= m_data;
			got_user     <= m_user;
			outputs_seen <= outputs_seen + 1;
		end
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic texel_t mem_byte(input tex_addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	// ------------------------------------------------
	// reference model
	// ------------------------------------------------

	// one byte per texel
	function automatic tex_addr_t model_addr(input int px, input int py);
		return cfg_base + tex_addr_t'(py) * cfg_stride + tex_addr_t'(px);
	endfunction

	function automatic texel_t model_texel(input int px, input int py);
		if (px >= cfg_width || py >= cfg_height)
			return texel_t'(`TEX_BORDER_DATA);
		return mem_byte(model_addr(px, py));
	endfunction

	// 8.4 coordinates with neighbours wrapping at 256
	function automatic texel_t model_sample(input tex_coord_t xc, input tex_coord_t yc);
		int xi;
		int yi;
		int fx;
		int fy;
		int acc;
		xi  = int'(xc[11:4]);
		yi  = int'(yc[11:4]);
		fx  = int'(xc[3:0]);
		fy  = int'(yc[3:0]);
		acc = int'(model_texel(xi, yi)) * (16 - fx) * (16 - fy)
			+ int'(model_texel((xi + 1) % 256, yi)) * fx * (16 - fy)
			+ int'(model_texel(xi, (yi + 1) % 256)) * (16 - fx) * fy
			+ int'(model_texel((xi + 1) % 256, (yi + 1) % 256)) * fx * fy;
		return texel_t'(acc >> 8);
	endfunction

	function automatic tex_coord_t make_coord(input int ipart, input int frac);
		return tex_coord_t'(ipart * 16 + frac);
	endfunction

	// ------------------------------------------------
	// driver tasks on the falling edge
	// ------------------------------------------------

	// one cycle then back-pressure and the memory model
	task automatic tick();
		@(negedge clk);
		m_ready     = (rand_bits(2) != 32'd0);
		mem_arready = (rand_bits(1) != 32'd0);
		mem_rvalid  = 1'b0;
		if (acc_seen) begin
			check_read_addr(acc_addr);
			mem_reads++;
			rd_pend   = 1'b1;
			rd_wait   = int'(rand_bits(2));
			mem_rdata = mem_byte(acc_addr);
		end
		if (rd_pend) begin
			if (rd_wait == 0) begin
				mem_rvalid = 1'b1;
				rd_pend    = 1'b0;
			end else begin
				rd_wait--;
			end
		end
	endtask

	// hits and border texels leave gaps in the fetch order
	task automatic check_read_addr(input tex_addr_t a);
		tex_addr_t first;
		logic      found;
		first = '0;
		found = 1'b0;
		if (exp_addrs.size() > 0)
			first = exp_addrs[0];
		while (exp_addrs.size() > 0 && !found) begin
			found = (exp_addrs[0] == a);
			void'(exp_addrs.pop_front());
		end
		checks++;
		assert (found) else begin
			$display("** Error %s mem_araddr: expected %0h, actual %0h", cur_test, first, a);
			errors++;
		end
	endtask

	task automatic check_value(input string field, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (exp == act) else begin
			$display("** Error %s %s: expected %0h, actual %0h", cur_test, field, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test       = name;
		test_err_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_err_start) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_failing++;
			$display("%s: %0d errors", cur_test, errors - test_err_start);
		end
	endtask

	task automatic write_param(input logic [1:0] sel, input tex_addr_t value);
		int rise;
		int busy;
		param_sel   = sel;
		param_wdata = value;
		param_wr    = 1'b1;
		tick();
		param_wr = 1'b0;
		case (sel)
			2'd0:    cfg_base   = value;
			2'd1:    cfg_width  = int'(value[7:0]);
			2'd2:    cfg_height = int'(value[7:0]);
			default: cfg_stride = value;
		endcase
		rise = 0;
		while (!clear_busy && rise < 8) begin
			tick();
			rise++;
		end
		busy = 0;
		while (clear_busy && busy < 32) begin
			tick();
			busy++;
		end
		check_value("clear start delay", 32'd1, rise);
		check_value("clear cycles", 32'd16, busy);
	endtask

	task automatic send_sample(input tex_coord_t xc, input tex_coord_t yc, input tex_user_t user);
		texel_t exp_data;
		int     target;
		int     xi;
		int     yi;
		int     px;
		int     py;
		exp_data = model_sample(xc, yc);
		target   = outputs_seen + 1;
		xi       = int'(xc[11:4]);
		yi       = int'(yc[11:4]);
		// neighbours in fetch order, border texels need no read
		exp_addrs.delete();
		for (int k = 0; k < 4; k++) begin
			px = (xi + k % 2) % 256;
			py = (yi + k / 2) % 256;
			if (px < cfg_width && py < cfg_height)
				exp_addrs.push_back(model_addr(px, py));
		end
		s_x      = xc;
		s_y      = yc;
		s_user   = user;
		s_valid  = 1'b1;
		while (!s_ready)
			tick();
		tick();
		s_valid = 1'b0;
		while (outputs_seen < target)
			tick();
		check_value("data", 32'(exp_data), 32'(got_data));
		check_value("user", 32'(user), 32'(got_user));
	endtask

	// ------------------------------------------------
	// test sequence
	// ------------------------------------------------

	initial begin
		int xi;
		int yi;
		int reads0;
		tex_coord_t xc;
		tex_coord_t yc;

		repeat (10)
			tick();
		rst = 1'b0;

		begin_test("reset_state");
		check_value("s_ready", 32'd1, 32'(s_ready));
		check_value("m_valid", 32'd0, 32'(m_valid));
		check_value("mem_arvalid", 32'd0, 32'(mem_arvalid));
		check_value("clear_busy", 32'd0, 32'(clear_busy));
		end_test();

		begin_test("param_clear");
		write_param(2'd0, 32'h0000_1a00);
		write_param(2'd1, 32'd40);
		write_param(2'd2, 32'd30);
		write_param(2'd3, 32'd64);
		end_test();

		begin_test("random_interior");
		for (int i = 0; i < NUM_RANDOM; i++) begin
			xi = int'(rand_bits(8)) % (cfg_width - 1);
			xc = make_coord(xi, int'(rand_bits(4)));
			yi = int'(rand_bits(8)) % (cfg_height - 1);
			yc = make_coord(yi, int'(rand_bits(4)));
			send_sample(xc, yc, tex_user_t'(rand_bits(4)));
			repeat (rand_bits(2))
				tick();
		end
		end_test();

		begin_test("border");
		for (int i = 0; i < NUM_BORDER; i++) begin
			if (i % 2 == 0) begin
				xi = cfg_width + int'(rand_bits(8)) % (255 - cfg_width);
				yi = int'(rand_bits(8));
			end else begin
				xi = int'(rand_bits(8));
				yi = cfg_height + int'(rand_bits(8)) % (255 - cfg_height);
			end
			xc     = make_coord(xi, int'(rand_bits(4)));
			yc     = make_coord(yi, int'(rand_bits(4)));
			reads0 = mem_reads;
			send_sample(xc, yc, tex_user_t'(rand_bits(4)));
			check_value("border reads", 32'd0, mem_reads - reads0);
		end
		// edge samples mixing image and border texels
		send_sample(make_coord(cfg_width - 1, 7), make_coord(3, 9), 4'h1);
		send_sample(make_coord(12, 5), make_coord(cfg_height - 1, 11), 4'h2);
		send_sample(make_coord(cfg_width - 1, 15), make_coord(cfg_height - 1, 8), 4'h3);
		send_sample(make_coord(255, 6), make_coord(4, 10), 4'h4);
		end_test();

		begin_test("hit_and_clear");
		xc = make_coord(5, 9);
		yc = make_coord(7, 3);
		send_sample(xc, yc, 4'h5);
		reads0 = mem_reads;
		send_sample(xc, yc, 4'h6);
		check_value("repeat reads", 32'd0, mem_reads - reads0);
		write_param(2'd0, 32'h0000_3700);
		reads0 = mem_reads;
		send_sample(xc, yc, 4'h7);
		check_value("refetch reads", 32'd4, mem_reads - reads0);
		end_test();

		$display("tests %0d, failing %0d, checks %0d, errors %0d",
			tests_run, tests_failing, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// run length bound from the sample and write counts
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog timeout, the DUT stopped responding in %s", cur_test);
		$display("test failed");
		$finish;
	end

endmodule

// ==== dv/tex_sampler_assert.sv ====
// ------------------------------------------------
// texture sampler handshake assertions
// output hold, memory address hold, clear length
// ------------------------------------------------

`timescale 1ns/1ps

module tex_sampler_assert import tex_pkg::*; (
	input logic      clk,
	input logic      rst,
	input texel_t    m_data,
	input tex_user_t m_user,
	input logic      m_valid,
	input logic      m_ready,
	input logic      mem_arvalid,
	input tex_addr_t mem_araddr,
	input logic      mem_arready,
	input logic      clear_busy
);

	// cycles clear_busy has been high in a row
	int busy_run;

	always_ff @(posedge clk) begin
		if (rst)
			busy_run <= 0;
		else if (clear_busy)
			busy_run <= busy_run + 1;
		else
			busy_run <= 0;
	end

	output_hold: assert property (@(posedge clk) disable iff (rst)
		m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_user))
		else $error("output changed while m_ready was low");

	addr_hold: assert property (@(posedge clk) disable iff (rst)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else $error("memory address changed while mem_arready was low");

	clear_length: assert property (@(posedge clk) disable iff (rst)
		clear_busy |-> busy_run < 16)
		else $error("clear_busy stayed high longer than 16 cycles");

endmodule

bind tex_sampler_top tex_sampler_assert tex_sampler_assert_inst (
	.clk         (clk),
	.rst         (rst),
	.m_data      (m_data),
	.m_user      (m_user),
	.m_valid     (m_valid),
	.m_ready     (m_ready),
	.mem_arvalid (mem_arvalid),
	.mem_araddr  (mem_araddr),
	.mem_arready (mem_arready),
	.clear_busy  (clear_busy)
);

// ==== hdl/tex_sampler_top.sv ====
// ------------------------------------------------
// texture sampler top level
// parameter registers, bilinear sampler and
// texel cache with a plain memory read port
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tex_sampler_top import tex_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,

	// parameter writes
	input  wire logic       param_wr,
	input  wire logic [1:0] param_sel,
	input  wire tex_addr_t  param_wdata,
	output logic            clear_busy,

	// sample input
	input  wire tex_coord_t s_x,
	input  wire tex_coord_t s_y,
	input  wire tex_user_t  s_user,
	input  wire logic       s_valid,
	output logic            s_ready,

	// filtered output
	output texel_t          m_data,
	output tex_user_t       m_user,
	output logic            m_valid,
	input  wire logic       m_ready,

	// memory read port
	output logic            mem_arvalid,
	output tex_addr_t       mem_araddr,
	input  wire logic       mem_arready,
	input  wire logic       mem_rvalid,
	input  wire texel_t     mem_rdata
);

	tex_cache_if cache_bus ();
	tex_param_if param_bus ();

	tex_param_regs tex_param_regs_inst (
		.clk         (clk),
		.rst         (rst),
		.param_wr    (param_wr),
		.param_sel   (param_sel),
		.param_wdata (param_wdata),
		.prm         (param_bus.regs)
	);

	tex_bilinear_unit tex_bilinear_unit_inst (
		.clk     (clk),
		.rst     (rst),
		.s_x     (s_x),
		.s_y     (s_y),
		.s_user  (s_user),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_data  (m_data),
		.m_user  (m_user),
		.m_valid (m_valid),
		.m_ready (m_ready),
		.mem     (cache_bus.sampler)
	);

	tex_cache_core tex_cache_core_inst (
		.clk         (clk),
		.rst         (rst),
		.req         (cache_bus.cache),
		.prm         (param_bus.cache),
		.clear_busy  (clear_busy),
		.mem_arvalid (mem_arvalid),
		.mem_araddr  (mem_araddr),
		.mem_arready (mem_arready),
		.mem_rvalid  (mem_rvalid),
		.mem_rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== cache/tex_cache_core.sv ====
// ------------------------------------------------
// direct mapped texel cache
// border check, single texel miss fetch and a
// line by line clear sequencer
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tex_cfg.svh"

module tex_cache_core import tex_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst,

	tex_cache_if.cache  req,
	tex_param_if.cache  prm,

	output logic        clear_busy,

	// memory read port
	output logic        mem_arvalid,
	output tex_addr_t   mem_araddr,
	input  wire logic   mem_arready,
	input  wire logic   mem_rvalid,
	input  wire texel_t mem_rdata
);

	localparam int IDX_W = `TEX_IDX_X_W + `TEX_IDX_Y_W;
	localparam int LINES = 1 << IDX_W;

	cache_state_t     state;
	logic             clear_pend;
	logic [IDX_W-1:0] clr_idx;
	logic [LINES-1:0] line_valid;

	tex_tag_t         tag_mem  [LINES];
	texel_t           data_mem [LINES];

	// registered request
	tex_xint_t        rx;
	tex_yint_t        ry;

	logic [IDX_W-1:0] line;
	tex_tag_t         tag;
	logic             border;
	logic             hit;

	assign line   = {ry[`TEX_IDX_Y_W-1:0], rx[`TEX_IDX_X_W-1:0]};
	assign tag    = {ry[`TEX_Y_INT_W-1:`TEX_IDX_Y_W], rx[`TEX_X_INT_W-1:`TEX_IDX_X_W]};
	assign border = (rx >= prm.width) || (ry >= prm.height);
	assign hit    = line_valid[line] && (tag_mem[line] == tag);

	assign clear_busy  = (state == CLEAR);
	// no new request while a clear is waiting to start
	assign req.arready = (state == READY) && !prm.clear_req && !clear_pend;

	// ------------------------------------------------
	// control
	// ------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= READY;
			clear_pend  <= 1'b0;
			clr_idx     <= '0;
			line_valid  <= '0;
			mem_arvalid <= 1'b0;
			req.rvalid  <= 1'b0;
		end else begin
			req.rvalid <= 1'b0;
			// clear requested mid-operation starts once idle
			if (prm.clear_req && state != READY)
				clear_pend <= 1'b1;

			case (state)
				READY: begin
					if (prm.clear_req || clear_pend) begin
						clear_pend <= 1'b0;
						clr_idx    <= '0;
						state      <= CLEAR;
					end else if (req.arvalid) begin
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (border || hit) begin
						req.rvalid <= 1'b1;
						state      <= READY;
					end else begin
						mem_arvalid <= 1'b1;
						state       <= FETCH;
					end
				end
				FETCH: begin
					if (mem_arvalid && mem_arready)
						mem_arvalid <= 1'b0;
					if (mem_rvalid) begin
						line_valid[line] <= 1'b1;
						req.rvalid       <= 1'b1;
						state            <= READY;
					end
				end
				CLEAR: begin
					line_valid[clr_idx] <= 1'b0;
					clr_idx             <= clr_idx + 1'b1;
					if (&clr_idx)
						state <= READY;
				end
				default: state <= READY;
			endcase
		end
	end

	// ------------------------------------------------
	// data and tag storage
	// ------------------------------------------------

	always_ff @(posedge clk) begin
		if (req.arvalid && req.arready) begin
			rx <= req.araddrx;
			ry <= req.araddry;
		end
		if (state == LOOKUP) begin
			req.rdata  <= border ? texel_t'(`TEX_BORDER_DATA) : data_mem[line];
			// one byte per texel
			mem_araddr <= prm.base + tex_addr_t'(ry) * prm.stride + tex_addr_t'(rx);
		end
		if (state == FETCH && mem_rvalid) begin
			req.rdata      <= mem_rdata;
			tag_mem[line]  <= tag;
			data_mem[line] <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== bilinear/tex_bilinear_unit.sv ====
// ------------------------------------------------
// bilinear sampler
// fetches the four neighbouring texels of a
// fixed point coordinate and blends them by the
// coordinate fraction
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tex_cfg.svh"

module tex_bilinear_unit import tex_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,

	// sample input
	input  wire tex_coord_t s_x,
	input  wire tex_coord_t s_y,
	input  wire tex_user_t  s_user,
	input  wire logic       s_valid,
	output logic            s_ready,

	// filtered output
	output texel_t          m_data,
	output tex_user_t       m_user,
	output logic            m_valid,
	input  wire logic       m_ready,

	tex_cache_if.sampler    mem
);

	// weights run 0..16, one bit wider than the fraction
	localparam int W_W   = `TEX_FRAC_W + 1;
	localparam int ACC_W = `TEX_DATA_W + 2 * W_W;

	bilin_state_t state;
	logic [1:0]   idx;

	tex_xint_t    x_int;
	tex_yint_t    y_int;
	tex_frac_t    fx;
	tex_frac_t    fy;
	texel_t       pix [4];

	logic [W_W-1:0]   wx0;
	logic [W_W-1:0]   wx1;
	logic [W_W-1:0]   wy0;
	logic [W_W-1:0]   wy1;
	logic [ACC_W-1:0] acc;

	// ------------------------------------------------
	// control
	// ------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			idx   <= 2'd0;
		end else begin
			case (state)
				IDLE: begin
					if (s_valid) begin
						idx   <= 2'd0;
						state <= REQ;
					end
				end
				REQ: begin
					if (mem.arready)
						state <= WAIT;
				end
				WAIT: begin
					if (mem.rvalid) begin
						if (idx == 2'd3) begin
							state <= CALC;
						end else begin
							idx   <= idx + 2'd1;
							state <= REQ;
						end
					end
				end
				CALC: state <= OUT;
				OUT: begin
					if (m_ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// texel order is (x,y) (x+1,y) (x,y+1) (x+1,y+1)
	assign mem.arvalid = (state == REQ);
	assign mem.araddrx = x_int + tex_xint_t'(idx[0]);
	assign mem.araddry = y_int + tex_yint_t'(idx[1]);

	assign s_ready = (state == IDLE);
	assign m_valid = (state == OUT);

	// ------------------------------------------------
	// datapath
	// ------------------------------------------------

	always_comb begin
		wx1 = {1'b0, fx};
		wy1 = {1'b0, fy};
		wx0 = W_W'(1 << `TEX_FRAC_W) - wx1;
		wy0 = W_W'(1 << `TEX_FRAC_W) - wy1;
		acc = ACC_W'(pix[0]) * ACC_W'(wx0) * ACC_W'(wy0)
			+ ACC_W'(pix[1]) * ACC_W'(wx1) * ACC_W'(wy0)
			+ ACC_W'(pix[2]) * ACC_W'(wx0) * ACC_W'(wy1)
			+ ACC_W'(pix[3]) * ACC_W'(wx1) * ACC_W'(wy1);
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready) begin
			x_int  <= s_x[`TEX_X_INT_W+`TEX_FRAC_W-1:`TEX_FRAC_W];
			fx     <= s_x[`TEX_FRAC_W-1:0];
			y_int  <= s_y[`TEX_Y_INT_W+`TEX_FRAC_W-1:`TEX_FRAC_W];
			fy     <= s_y[`TEX_FRAC_W-1:0];
			m_user <= s_user;
		end
		if (state == WAIT && mem.rvalid)
			pix[idx] <= mem.rdata;
		// drop the fraction bits of both weights
		if (state == CALC)
			m_data <= acc[`TEX_DATA_W+2*`TEX_FRAC_W-1:2*`TEX_FRAC_W];
	end

endmodule

`default_nettype wire

// ==== hdl/tex_param_regs.sv ====
// ------------------------------------------------
// texture parameter registers
// holds base, width, height and stride
// every write requests a cache clear
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tex_param_regs import tex_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,

	input  wire logic      param_wr,
	input  wire logic [1:0] param_sel,
	input  wire tex_addr_t param_wdata,

	tex_param_if.regs      prm
);

	tex_addr_t base_q;
	tex_xint_t width_q;
	tex_yint_t height_q;
	tex_addr_t stride_q;
	logic      clear_q;

	// width and height start at 0 so all samples are border
	always_ff @(posedge clk) begin
		if (rst) begin
			base_q   <= '0;
			width_q  <= '0;
			height_q <= '0;
			stride_q <= '0;
			clear_q  <= 1'b0;
		end else begin
			clear_q <= param_wr;
			if (param_wr) begin
				case (param_sel)
					2'd0:    base_q   <= param_wdata;
					2'd1:    width_q  <= tex_xint_t'(param_wdata);
					2'd2:    height_q <= tex_yint_t'(param_wdata);
					default: stride_q <= param_wdata;
				endcase
			end
		end
	end

	assign prm.base      = base_q;
	assign prm.width     = width_q;
	assign prm.height    = height_q;
	assign prm.stride    = stride_q;
	assign prm.clear_req = clear_q;

endmodule

`default_nettype wire

// ==== common/tex_param_if.sv ====
// ------------------------------------------------
// texture parameter bus
// image geometry and clear request to the cache
// ------------------------------------------------

`timescale 1ns/1ps

interface tex_param_if import tex_pkg::*; ();

	tex_addr_t base;
	tex_xint_t width;
	tex_yint_t height;
	tex_addr_t stride;

	// single cycle pulse per register write
	logic      clear_req;

	modport regs (
		output base, width, height, stride, clear_req
	);

	modport cache (
		input  base, width, height, stride, clear_req
	);

endinterface

// ==== common/tex_cache_if.sv ====
// ------------------------------------------------
// texel read channel
// sampler to cache, one request outstanding
// ------------------------------------------------

`timescale 1ns/1ps

interface tex_cache_if import tex_pkg::*; ();

	// request
	tex_xint_t araddrx;
	tex_yint_t araddry;
	logic      arvalid;
	logic      arready;

	// response, always accepted by the sampler
	texel_t    rdata;
	logic      rvalid;

	modport sampler (
		output araddrx, araddry, arvalid,
		input  arready, rdata, rvalid
	);

	modport cache (
		input  araddrx, araddry, arvalid,
		output arready, rdata, rvalid
	);

endinterface

// ==== common/tex_pkg.sv ====
// ------------------------------------------------
// texture sampler package
// shared vector types and state encodings
// ------------------------------------------------

`include "tex_cfg.svh"

package tex_pkg;

	typedef logic [`TEX_X_INT_W-1:0]               tex_xint_t;
	typedef logic [`TEX_Y_INT_W-1:0]               tex_yint_t;
	typedef logic [`TEX_X_INT_W+`TEX_FRAC_W-1:0]   tex_coord_t;
	typedef logic [`TEX_FRAC_W-1:0]                tex_frac_t;
	typedef logic [`TEX_DATA_W-1:0]                texel_t;
	typedef logic [`TEX_ADDR_W-1:0]                tex_addr_t;
	typedef logic [`TEX_USER_W-1:0]                tex_user_t;

	// upper coordinate bits not used as cache index
	typedef logic [`TEX_Y_INT_W-`TEX_IDX_Y_W+`TEX_X_INT_W-`TEX_IDX_X_W-1:0] tex_tag_t;

	// bilinear sampler FSM
	typedef enum logic [2:0] {IDLE, REQ, WAIT, CALC, OUT} bilin_state_t;

	// texel cache FSM
	typedef enum logic [1:0] {READY, LOOKUP, FETCH, CLEAR} cache_state_t;

endpackage

// ==== common/tex_cfg.svh ====
// ------------------------------------------------
// texture sampler configuration
// widths, cache geometry and border texel value
// ------------------------------------------------

`ifndef TEX_CFG_SVH
`define TEX_CFG_SVH

// coordinate format, integer and fraction bits
`define TEX_X_INT_W     8
`define TEX_Y_INT_W     8
`define TEX_FRAC_W      4

`define TEX_DATA_W      8
`define TEX_ADDR_W      32
`define TEX_USER_W      4

// cache index bits per axis, 4x4 lines
`define TEX_IDX_X_W     2
`define TEX_IDX_Y_W     2

`define TEX_BORDER_DATA 8'h00

`endif
